// ==== lsu_pkg.sv ====
/* Load/store unit shared definitions */

package lsu_pkg;

    ////////////////////////////////////////
    // Widths and limits
    ////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int STRB_W     = XLEN / 8;
    localparam int NB_INT_REG = 32;
    localparam int REG_ADDR_W = 5;
    // Outstanding requests allowed in each direction
    localparam int MAX_OR     = 4;
    localparam int OR_CNT_W   = $clog2(MAX_OR + 1);
    // Index width of the load context FIFO
    localparam int CTX_AW     = $clog2(MAX_OR);

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OR_CNT_W-1:0]   or_cnt_t;

    // RV32 major opcodes handled here
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } lsu_op_t;

    // funct3 access sizes
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } lsu_size_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WAIT  = 2'd1,
        ST_SERVE = 2'd2
    } lsu_state_t;

    ////////////////////////////////////////
    // Alignment helpers
    ////////////////////////////////////////

    // Copy the stored value onto every lane it may land on
    function automatic xlen_t store_data(lsu_size_t size, xlen_t rs2);
        case (size)
            SIZE_B, SIZE_BU: return {STRB_W{rs2[7:0]}};
            SIZE_H, SIZE_HU: return {(STRB_W/2){rs2[15:0]}};
            default:         return rs2;
        endcase
    endfunction

    // Byte enables placed at the address offset
    function automatic strb_t store_strb(lsu_size_t size, logic [1:0] offset);
        case (size)
            SIZE_B, SIZE_BU: return strb_t'(4'b0001) << offset;
            SIZE_H, SIZE_HU: return strb_t'(4'b0011) << offset;
            default:         return {STRB_W{1'b1}};
        endcase
    endfunction

    // Shift the addressed lane down, then sign or zero extend
    function automatic xlen_t load_data(lsu_size_t size, xlen_t data, logic [1:0] offset);
        xlen_t lane;
        lane = data >> {offset, 3'b000};
        case (size)
            SIZE_B:  return {{(XLEN-8){lane[7]}}, lane[7:0]};
            SIZE_BU: return {{(XLEN-8){1'b0}}, lane[7:0]};
            SIZE_H:  return {{(XLEN-16){lane[15]}}, lane[15:0]};
            SIZE_HU: return {{(XLEN-16){1'b0}}, lane[15:0]};
            default: return lane;
        endcase
    endfunction

    function automatic logic is_misaligned(lsu_size_t size, logic [1:0] offset);
        case (size)
            SIZE_H, SIZE_HU: return offset[0];
            SIZE_W:          return offset != 2'b00;
            default:         return 1'b0;
        endcase
    endfunction

endpackage

// ==== lsu_issue_fsm.sv ====
/* Load/store issue FSM */

`timescale 1ns/1ps

module lsu_issue_fsm (
    input  logic                aclk,
    input  logic                aresetn,
    // Instruction side
    input  logic                instr_valid,
    output logic                instr_ready,
    input  lsu_pkg::lsu_op_t    instr_opcode,
    input  lsu_pkg::lsu_size_t  instr_size,
    input  lsu_pkg::reg_addr_t  instr_rd,
    input  lsu_pkg::xlen_t      instr_rs1_val,
    input  lsu_pkg::xlen_t      instr_rs2_val,
    input  logic [11:0]         instr_imm12,
    output logic                load_misaligned,
    output logic                store_misaligned,
    // AXI4-lite request channels
    output logic                awvalid,
    input  logic                awready,
    output lsu_pkg::xlen_t      awaddr,
    output logic                wvalid,
    input  logic                wready,
    output lsu_pkg::xlen_t      wdata,
    output lsu_pkg::strb_t      wstrb,
    output logic                arvalid,
    input  logic                arready,
    output lsu_pkg::xlen_t      araddr,
    // Tracker and load context
    input  logic                wr_waiting,
    input  logic                rd_waiting,
    input  logic                wr_at_max,
    input  logic                ctx_full,
    output logic                wr_issue,
    output logic                rd_issue,
    output logic [1:0]          ctx_offset
);

    import lsu_pkg::*;

    lsu_state_t state;
    xlen_t      eff_addr;
    logic       armed;
    logic       load_r;
    logic       stall;
    logic       accept;
    logic       is_load;
    logic       is_store;
    logic       misaligned;

    ////////////////////////////////////////
    // Address and decode
    ////////////////////////////////////////

    // rs1 plus sign extended immediate
    assign eff_addr   = instr_rs1_val + {{(XLEN-12){instr_imm12[11]}}, instr_imm12};
    assign ctx_offset = eff_addr[1:0];

    assign is_load    = (instr_opcode == OP_LOAD);
    assign is_store   = (instr_opcode == OP_STORE);
    assign misaligned = is_misaligned(instr_size, eff_addr[1:0]);

    // A raised channel still waiting for its ready
    assign stall = (awvalid & ~awready) | (wvalid & ~wready) | (arvalid & ~arready);

    // No room for another read context or write completion
    assign instr_ready = armed & (state == ST_IDLE) & ~stall & ~ctx_full & ~wr_at_max;
    assign accept      = instr_valid & instr_ready;

    // Exceptions flag in the acceptance cycle, nothing goes out
    assign load_misaligned  = accept & is_load & misaligned;
    assign store_misaligned = accept & is_store & misaligned;

    assign wr_issue = accept & is_store & ~misaligned;
    assign rd_issue = accept & is_load & ~misaligned;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= ST_IDLE;
            armed   <= 1'b0;
            load_r  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            armed <= 1'b1;
            // Release each channel once the slave took it
            if (awready) begin
                awvalid <= 1'b0;
            end
            if (wready) begin
                wvalid <= 1'b0;
            end
            if (arready) begin
                arvalid <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (stall) begin
                        // Hold the payload until every channel handshakes
                        state <= ST_SERVE;
                    end else if (wr_issue) begin
                        load_r <= 1'b0;
                        // Reads in flight must complete before a write
                        if (rd_waiting) begin
                            state <= ST_WAIT;
                        end else begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                        end
                    end else if (rd_issue) begin
                        load_r <= 1'b1;
                        if (wr_waiting) begin
                            state <= ST_WAIT;
                        end else begin
                            arvalid <= 1'b1;
                        end
                    end
                end

                // Direction change, wait for the other side to drain
                ST_WAIT: begin
                    if (load_r && !wr_waiting) begin
                        arvalid <= 1'b1;
                        state   <= ST_SERVE;
                    end else if (!load_r && !rd_waiting) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= ST_SERVE;
                    end
                end

                default: begin
                    if (!stall) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Request payload, loaded only when a new request is taken
    always_ff @(posedge aclk) begin
        if (wr_issue) begin
            awaddr <= eff_addr;
            wdata  <= store_data(instr_size, instr_rs2_val);
            wstrb  <= store_strb(instr_size, eff_addr[1:0]);
        end
        if (rd_issue) begin
            araddr <= eff_addr;
        end
    end

endmodule

// ==== lsu_or_tracker.sv ====
/* Outstanding request tracker */

`timescale 1ns/1ps

module lsu_or_tracker (
    input  logic aclk,
    input  logic aresetn,
    input  logic wr_issue,
    input  logic rd_issue,
    input  logic bvalid,
    input  logic rd_done,
    output logic wr_waiting,
    output logic rd_waiting,
    output logic wr_at_max,
    output logic pending_read,
    output logic pending_write
);

    import lsu_pkg::*;

    or_cnt_t wr_cnt;
    or_cnt_t rd_cnt;

    // Issue and completion together leave a counter as is
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_cnt <= '0;
            rd_cnt <= '0;
        end else begin
            if (wr_issue && !bvalid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end else if (!wr_issue && bvalid && wr_cnt != '0) begin
                wr_cnt <= wr_cnt - 1'b1;
            end
            if (rd_issue && !rd_done) begin
                rd_cnt <= rd_cnt + 1'b1;
            end else if (!rd_issue && rd_done && rd_cnt != '0) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
        end
    end

    // Last completion arriving now already frees the direction
    assign wr_waiting = (wr_cnt != '0) & ~((wr_cnt == or_cnt_t'(1)) & bvalid);
    assign rd_waiting = (rd_cnt != '0) & ~((rd_cnt == or_cnt_t'(1)) & rd_done);

    assign wr_at_max = (wr_cnt == or_cnt_t'(MAX_OR));

    assign pending_read  = rd_waiting;
    assign pending_write = wr_waiting;

endmodule

// ==== lsu_load_return.sv ====
/* Load completion path */

`timescale 1ns/1ps

module lsu_load_return (
    input  logic               aclk,
    input  logic               aresetn,
    // Context push from the issue side
    input  logic               rd_issue,
    input  lsu_pkg::reg_addr_t instr_rd,
    input  lsu_pkg::lsu_size_t instr_size,
    input  logic [1:0]         ctx_offset,
    output logic               ctx_full,
    // Read data channel
    input  logic               rvalid,
    input  lsu_pkg::xlen_t     rdata,
    // Register write
    output logic               rd_done,
    output logic               rd_wr,
    output lsu_pkg::reg_addr_t rd_addr,
    output lsu_pkg::xlen_t     rd_val,
    output lsu_pkg::strb_t     rd_strb
);

    import lsu_pkg::*;

    // Pointers carry one extra wrap bit
    logic [CTX_AW:0]   wr_ptr;
    logic [CTX_AW:0]   rd_ptr;
    logic [CTX_AW-1:0] head;

    reg_addr_t  ctx_rd   [MAX_OR];
    lsu_size_t  ctx_size [MAX_OR];
    logic [1:0] ctx_off  [MAX_OR];

    ////////////////////////////////////////
    // Context FIFO
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (rd_issue) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Responses come back in request order
            if (rvalid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_issue) begin
            ctx_rd[wr_ptr[CTX_AW-1:0]]   <= instr_rd;
            ctx_size[wr_ptr[CTX_AW-1:0]] <= instr_size;
            ctx_off[wr_ptr[CTX_AW-1:0]]  <= ctx_offset;
        end
    end

    // Same slot, other lap
    assign ctx_full = (wr_ptr[CTX_AW] != rd_ptr[CTX_AW]) &&
                      (wr_ptr[CTX_AW-1:0] == rd_ptr[CTX_AW-1:0]);

    assign head = rd_ptr[CTX_AW-1:0];

    ////////////////////////////////////////
    // Register write
    ////////////////////////////////////////

    // rready is tied high, every rvalid completes a load
    assign rd_done = rvalid;
    assign rd_wr   = rvalid;
    assign rd_addr = ctx_rd[head];
    assign rd_val  = load_data(ctx_size[head], rdata, ctx_off[head]);
    // Extension fills the whole register
    assign rd_strb = {STRB_W{1'b1}};

endmodule

// ==== lsu_reg_busy.sv ====
/* Register busy counter */

`timescale 1ns/1ps

module lsu_reg_busy (
    input  logic               aclk,
    input  logic               aresetn,
    input  lsu_pkg::reg_addr_t reg_index,
    input  logic               rd_issue,
    input  lsu_pkg::reg_addr_t instr_rd,
    input  logic               rd_wr,
    input  lsu_pkg::reg_addr_t rd_addr,
    output logic               busy
);

    import lsu_pkg::*;

    or_cnt_t cnt;
    logic    inc;
    logic    dec;

    // Loads issued to and returned into this register
    assign inc = rd_issue & (instr_rd == reg_index);
    assign dec = rd_wr & (rd_addr == reg_index);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cnt <= '0;
        end else if (inc && !dec) begin
            cnt <= cnt + 1'b1;
        end else if (dec && !inc && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign busy = (cnt != '0);

endmodule

// ==== lsu_top.sv ====
/* RV32 load/store unit */

`timescale 1ns/1ps

module lsu_top (
    input  logic                                aclk,
    input  logic                                aresetn,
    // Instruction side
    input  logic                                instr_valid,
    output logic                                instr_ready,
    input  lsu_pkg::lsu_op_t                    instr_opcode,
    input  lsu_pkg::lsu_size_t                  instr_size,
    input  lsu_pkg::reg_addr_t                  instr_rd,
    input  lsu_pkg::xlen_t                      instr_rs1_val,
    input  lsu_pkg::xlen_t                      instr_rs2_val,
    input  logic [11:0]                         instr_imm12,
    // Exceptions and status
    output logic                                load_misaligned,
    output logic                                store_misaligned,
    output logic                                pending_read,
    output logic                                pending_write,
    output logic [lsu_pkg::NB_INT_REG-1:0]      reg_busy,
    // Register write
    output logic                                rd_wr,
    output lsu_pkg::reg_addr_t                  rd_addr,
    output lsu_pkg::xlen_t                      rd_val,
    output lsu_pkg::strb_t                      rd_strb,
    // AXI4-lite master
    output logic                                awvalid,
    input  logic                                awready,
    output lsu_pkg::xlen_t                      awaddr,
    output logic                                wvalid,
    input  logic                                wready,
    output lsu_pkg::xlen_t                      wdata,
    output lsu_pkg::strb_t                      wstrb,
    input  logic                                bvalid,
    output logic                                bready,
    input  logic [1:0]                          bresp,
    output logic                                arvalid,
    input  logic                                arready,
    output lsu_pkg::xlen_t                      araddr,
    input  logic                                rvalid,
    output logic                                rready,
    input  lsu_pkg::xlen_t                      rdata,
    input  logic [1:0]                          rresp
);

    import lsu_pkg::*;

    logic       wr_issue;
    logic       rd_issue;
    logic       wr_waiting;
    logic       rd_waiting;
    logic       wr_at_max;
    logic       ctx_full;
    logic       rd_done;
    logic [1:0] ctx_offset;

    // Completions always taken, response codes carry no action here
    assign bready = 1'b1;
    assign rready = 1'b1;

    lsu_issue_fsm u_issue_fsm (.*);

    lsu_or_tracker u_or_tracker (.*);

    lsu_load_return u_load_return (.*);

    ////////////////////////////////////////
    // Per register busy status
    ////////////////////////////////////////

    // x0 never waits on a load
    assign reg_busy[0] = 1'b0;

    for (genvar i = 1; i < NB_INT_REG; i++) begin : g_reg_busy
        lsu_reg_busy u_reg_busy (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .reg_index (reg_addr_t'(i)),
            .rd_issue  (rd_issue),
            .instr_rd  (instr_rd),
            .rd_wr     (rd_wr),
            .rd_addr   (rd_addr),
            .busy      (reg_busy[i])
        );
    end

endmodule

// ==== tb_lsu.sv ====
/* Load/store unit testbench */

`timescale 1ns/1ps

module tb_lsu;

    import lsu_pkg::*;

    localparam int MAX_ROWS = 48;
    // Byte window the slave model decodes
    localparam xlen_t MEM_BASE = 32'h100;

    logic aclk    = 1'b0;
    logic aresetn = 1'b0;

    // Instruction side
    logic        instr_valid   = 1'b0;
    logic        instr_ready;
    lsu_op_t     instr_opcode  = OP_LOAD;
    lsu_size_t   instr_size    = SIZE_W;
    reg_addr_t   instr_rd      = '0;
    xlen_t       instr_rs1_val = '0;
    xlen_t       instr_rs2_val = '0;
    logic [11:0] instr_imm12   = '0;
    logic        load_misaligned;
    logic        store_misaligned;
    logic        pending_read;
    logic        pending_write;
    logic [NB_INT_REG-1:0] reg_busy;
    logic        rd_wr;
    reg_addr_t   rd_addr;
    xlen_t       rd_val;
    strb_t       rd_strb;

    // AXI4-lite slave side
    logic        awvalid;
    logic        awready = 1'b0;
    xlen_t       awaddr;
    logic        wvalid;
    logic        wready  = 1'b0;
    xlen_t       wdata;
    strb_t       wstrb;
    logic        bvalid  = 1'b0;
    logic        bready;
    logic [1:0]  bresp   = 2'b00;
    logic        arvalid;
    logic        arready = 1'b0;
    xlen_t       araddr;
    logic        rvalid  = 1'b0;
    logic        rready;
    xlen_t       rdata   = '0;
    logic [1:0]  rresp   = 2'b00;

    // Stimulus table, one instruction per row
    lsu_op_t     t_op   [MAX_ROWS];
    lsu_size_t   t_size [MAX_ROWS];
    reg_addr_t   t_rd   [MAX_ROWS];
    xlen_t       t_rs1  [MAX_ROWS];
    logic [11:0] t_imm  [MAX_ROWS];
    xlen_t       t_rs2  [MAX_ROWS];
    logic        t_exc  [MAX_ROWS];
    int          n_rows = 0;

    // Slave memory and the program order reference
    logic [7:0] mem     [64];
    logic [7:0] ref_mem [64];

    xlen_t     aw_q[$];
    xlen_t     wd_q[$];
    strb_t     ws_q[$];
    xlen_t     ar_q[$];
    reg_addr_t exp_rd_q[$];
    xlen_t     exp_val_q[$];

    int b_pend  = 0;
    int wr_open = 0;
    int rd_open = 0;
    int aw_cnt  = 0;
    int w_cnt   = 0;
    int ar_cnt  = 0;
    int exp_st  = 0;
    int exp_ld  = 0;
    int chk_cnt = 0;
    int err_cnt = 0;

    logic [NB_INT_REG-1:0] prev_busy = '0;
    logic [31:0]           lfsr      = 32'he9b5;

    lsu_top u_dut (.*);

    always #4 aclk = ~aclk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Galois LFSR, one step per bit
    function automatic logic rand_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'hd0000001;
        end
        return out;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        chk_cnt++;
        if (actual !== expected) begin
            $display("FAILED at %0t: %s (got %h, expected %h)", $time, what, actual, expected);
            err_cnt++;
        end
    endtask

    task automatic add_row(input lsu_op_t op, input lsu_size_t size, input reg_addr_t rd,
                           input xlen_t rs1, input logic [11:0] imm, input xlen_t rs2,
                           input logic exc);
        t_op[n_rows]   = op;
        t_size[n_rows] = size;
        t_rd[n_rows]   = rd;
        t_rs1[n_rows]  = rs1;
        t_imm[n_rows]  = imm;
        t_rs2[n_rows]  = rs2;
        t_exc[n_rows]  = exc;
        n_rows++;
    endtask

    // Little endian word at the word address
    function automatic xlen_t word_at(input xlen_t a);
        return {mem[{a[5:2], 2'd3}], mem[{a[5:2], 2'd2}],
                mem[{a[5:2], 2'd1}], mem[{a[5:2], 2'd0}]};
    endfunction

    // Byte by byte update of the reference, low byte first
    task automatic ref_store(input lsu_size_t size, input xlen_t a, input xlen_t v);
        logic [5:0] p;
        p = a[5:0];
        ref_mem[p] = v[7:0];
        if (size != SIZE_B && size != SIZE_BU) begin
            ref_mem[p + 6'd1] = v[15:8];
        end
        if (size == SIZE_W) begin
            ref_mem[p + 6'd2] = v[23:16];
            ref_mem[p + 6'd3] = v[31:24];
        end
    endtask

    function automatic xlen_t ref_load(input lsu_size_t size, input xlen_t a);
        logic [5:0] p;
        logic [7:0] b0;
        logic [7:0] b1;
        p  = a[5:0];
        b0 = ref_mem[p];
        b1 = ref_mem[p + 6'd1];
        case (size)
            SIZE_B:  return {{24{b0[7]}}, b0};
            SIZE_BU: return {24'h0, b0};
            SIZE_H:  return {{16{b1[7]}}, b1, b0};
            SIZE_HU: return {16'h0, b1, b0};
            default: return {ref_mem[p + 6'd3], ref_mem[p + 6'd2], b1, b0};
        endcase
    endfunction

    // Apply one write once both its address and data were taken
    task automatic commit_write();
        xlen_t a;
        xlen_t d;
        strb_t s;
        a = aw_q.pop_front();
        d = wd_q.pop_front();
        s = ws_q.pop_front();
        for (int j = 0; j < 4; j++) begin
            if (s[j]) begin
                mem[{a[5:2], j[1:0]}] = d[8*j +: 8];
            end
        end
        b_pend++;
    endtask

    ////////////////////////////////////////
    // AXI4-lite memory model
    ////////////////////////////////////////

    always @(negedge aclk) begin : mem_model
        logic b_now;
        logic r_now;
        b_now  = 1'b0;
        r_now  = 1'b0;
        bvalid = 1'b0;
        rvalid = 1'b0;
        // Responses in request order, random delay
        if (b_pend > 0 && rand_bit()) begin
            bvalid = 1'b1;
            b_now  = 1'b1;
        end
        if (ar_q.size() > 0 && rand_bit()) begin
            rvalid = 1'b1;
            r_now  = 1'b1;
            rdata  = word_at(ar_q.pop_front());
        end
        awready = rand_bit();
        wready  = rand_bit();
        arready = rand_bit();
        #1;
        // Completions are always accepted
        check(32'(bready), 32'd1, "bready held high");
        check(32'(rready), 32'd1, "rready held high");
        // Handshakes below complete on the coming rising edge
        if (awvalid && awready) begin
            check(rd_open, 0, "AW handshake with reads outstanding");
            check(awaddr & ~32'h3f, MEM_BASE, "AW address in memory window");
            aw_q.push_back(awaddr);
            wr_open++;
            aw_cnt++;
        end
        if (wvalid && wready) begin
            wd_q.push_back(wdata);
            ws_q.push_back(wstrb);
            w_cnt++;
        end
        if (arvalid && arready) begin
            check(wr_open, 0, "AR handshake with writes outstanding");
            check(araddr & ~32'h3f, MEM_BASE, "AR address in memory window");
            ar_q.push_back(araddr);
            rd_open++;
            ar_cnt++;
        end
        if (aw_q.size() > 0 && wd_q.size() > 0) begin
            commit_write();
        end
        check(32'(rd_wr), 32'(rvalid), "rd_wr follows rvalid");
        if (r_now) begin
            if (exp_rd_q.size() == 0) begin
                check(32'd1, 32'd0, "read data with no load expected");
            end else begin
                check(32'(prev_busy[rd_addr]), 32'd1, "reg_busy set before load write");
                check(32'(rd_addr), 32'(exp_rd_q.pop_front()), "load destination order");
                check(rd_val, exp_val_q.pop_front(), "load value");
                check(32'(rd_strb), 32'hf, "register write strobe");
            end
            rd_open--;
        end
        if (b_now) begin
            b_pend--;
            wr_open--;
        end
        prev_busy = reg_busy;
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        logic  is_ld;
        xlen_t ea;

        // Stores of each size, then loads of each size
        add_row(OP_STORE, SIZE_W,  5'd0,  32'h100, 12'h000, 32'hdeadbeef, 1'b0);
        add_row(OP_STORE, SIZE_W,  5'd0,  32'h100, 12'h004, 32'h80817f01, 1'b0);
        add_row(OP_STORE, SIZE_H,  5'd0,  32'h100, 12'h008, 32'h0000f00d, 1'b0);
        add_row(OP_STORE, SIZE_H,  5'd0,  32'h100, 12'h00a, 32'h12347ffe, 1'b0);
        add_row(OP_STORE, SIZE_B,  5'd0,  32'h100, 12'h00c, 32'h00000085, 1'b0);
        add_row(OP_STORE, SIZE_B,  5'd0,  32'h100, 12'h00d, 32'h0000007a, 1'b0);
        add_row(OP_STORE, SIZE_B,  5'd0,  32'h100, 12'h00e, 32'h000000ff, 1'b0);
        add_row(OP_STORE, SIZE_B,  5'd0,  32'h100, 12'h00f, 32'h00000001, 1'b0);
        add_row(OP_LOAD,  SIZE_W,  5'd1,  32'h100, 12'h000, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_W,  5'd2,  32'h100, 12'h004, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_B,  5'd3,  32'h100, 12'h004, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_B,  5'd4,  32'h100, 12'h007, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_BU, 5'd5,  32'h100, 12'h006, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_H,  5'd6,  32'h100, 12'h008, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_HU, 5'd7,  32'h100, 12'h008, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_H,  5'd8,  32'h100, 12'h00a, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_W,  5'd9,  32'h100, 12'h00c, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_B,  5'd10, 32'h100, 12'h00c, 32'h0, 1'b0);
        // Misaligned accesses, then proof that memory kept its contents
        add_row(OP_STORE, SIZE_W,  5'd0,  32'h100, 12'h002, 32'h55aa55aa, 1'b1);
        add_row(OP_LOAD,  SIZE_H,  5'd11, 32'h100, 12'h009, 32'h0, 1'b1);
        add_row(OP_LOAD,  SIZE_W,  5'd12, 32'h100, 12'h000, 32'h0, 1'b0);
        // Negative offsets
        add_row(OP_STORE, SIZE_H,  5'd0,  32'h140, 12'hfc2, 32'h0000abcd, 1'b0);
        add_row(OP_LOAD,  SIZE_W,  5'd13, 32'h104, 12'hffc, 32'h0, 1'b0);
        // Fill pattern region, same register loaded twice in flight
        add_row(OP_LOAD,  SIZE_W,  5'd1,  32'h100, 12'h010, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_HU, 5'd1,  32'h100, 12'h022, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_W,  5'd15, 32'h100, 12'h021, 32'h0, 1'b1);
        add_row(OP_STORE, SIZE_B,  5'd0,  32'h100, 12'h021, 32'h0000003c, 1'b0);
        add_row(OP_LOAD,  SIZE_BU, 5'd15, 32'h100, 12'h021, 32'h0, 1'b0);
        add_row(OP_LOAD,  SIZE_W,  5'd16, 32'h100, 12'h020, 32'h0, 1'b0);
        add_row(OP_STORE, SIZE_H,  5'd0,  32'h100, 12'h023, 32'h00001111, 1'b1);
        add_row(OP_LOAD,  SIZE_H,  5'd17, 32'h100, 12'h022, 32'h0, 1'b0);

        for (int i = 0; i < 64; i++) begin
            mem[i]     = 8'(i * 29 + 167);
            ref_mem[i] = 8'(i * 29 + 167);
        end

        repeat (10) @(negedge aclk);
        check(32'(instr_ready), 32'd0, "instr_ready low in reset");
        check(32'(awvalid | wvalid | arvalid), 32'd0, "AXI requests low in reset");
        aresetn = 1'b1;

        for (int i = 0; i < n_rows; i++) begin
            @(negedge aclk);
            instr_valid   = 1'b1;
            instr_opcode  = t_op[i];
            instr_size    = t_size[i];
            instr_rd      = t_rd[i];
            instr_rs1_val = t_rs1[i];
            instr_imm12   = t_imm[i];
            instr_rs2_val = t_rs2[i];
            #1;
            while (!instr_ready) begin
                @(negedge aclk);
                #1;
            end
            // Accepted on the coming edge, exception flags pulse now
            is_ld = (t_op[i] == OP_LOAD);
            check(32'(load_misaligned), 32'(is_ld & t_exc[i]), "load misaligned flag");
            check(32'(store_misaligned), 32'(!is_ld & t_exc[i]), "store misaligned flag");
            ea = t_rs1[i] + {{20{t_imm[i][11]}}, t_imm[i]};
            if (!t_exc[i]) begin
                if (is_ld) begin
                    exp_rd_q.push_back(t_rd[i]);
                    exp_val_q.push_back(ref_load(t_size[i], ea));
                    exp_ld++;
                end else begin
                    ref_store(t_size[i], ea, t_rs2[i]);
                    exp_st++;
                end
            end
        end
        @(negedge aclk);
        instr_valid = 1'b0;

        // Drain every completion, then let the status settle
        while (exp_rd_q.size() != 0 || wr_open != 0 || rd_open != 0 || b_pend != 0) begin
            @(negedge aclk);
        end
        repeat (3) @(negedge aclk);
        #2;
        check(32'(pending_read), 32'd0, "pending_read after drain");
        check(32'(pending_write), 32'd0, "pending_write after drain");
        check(reg_busy, 32'd0, "reg_busy after drain");
        check(32'(instr_ready), 32'd1, "instr_ready after drain");
        check(aw_cnt, exp_st, "AW handshake count");
        check(w_cnt, exp_st, "W handshake count");
        check(ar_cnt, exp_ld, "AR handshake count");

        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (aresetn);
        repeat (n_rows * 200 + 1000) @(posedge aclk);
        $display("Timeout: the table did not drain within %0d cycles", n_rows * 200 + 1000);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== project.f ====
lsu_pkg.sv
lsu_issue_fsm.sv
lsu_or_tracker.sv
lsu_load_return.sv
lsu_reg_busy.sv
lsu_top.sv
tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_lsu -f project.f

output=$(./obj_dir/Vtb_lsu)
echo "$output"
echo "$output" | grep -qx "Test passed"
